/* bench/bus_memory.sv */
module bus_memory #(
        parameter isa_pkg::word_t IMEM_BASE = '0
) (
        input  logic                clk,
        input  logic                rst_n,
        input  isa_pkg::word_t      ibus_addr_i,
        input  logic                ibus_read_i,
        output isa_pkg::word_t      ibus_rdata_o,
        output logic                ibus_stall_o,
        input  pipe_pkg::dbus_req_t dbus_req_i,
        output isa_pkg::word_t      dbus_rdata_o,
        output logic                dbus_stall_o
);

        import isa_pkg::*;

        word_t imem [256];
        word_t dmem [16];      // Data window of 16 words.
        word_t ioffs;

        assign ioffs = ibus_addr_i - IMEM_BASE;

        // Garbage unless a read is presented and not stalled.
        assign ibus_rdata_o = (ibus_stall_o || !ibus_read_i) ? 32'hdead_beef : imem[ioffs[9:2]];
        assign dbus_rdata_o = (dbus_stall_o || !dbus_req_i.read) ? 32'hdead_beef
                                                                 : dmem[dbus_req_i.addr[5:2]];

        initial begin
                ibus_stall_o <= 1'b0;
                dbus_stall_o <= 1'b0;
        end

        always @(negedge clk) begin
                ibus_stall_o <= rst_n && ($urandom_range(0, 99) < 20);
                dbus_stall_o <= rst_n && ($urandom_range(0, 99) < 20);
        end

        always @(posedge clk) begin
                if (rst_n && dbus_req_i.write && !dbus_stall_o) begin
                        dmem[dbus_req_i.addr[5:2]] <= dbus_req_i.wdata;
                end
        end

endmodule

/* bench/mips_core_sva.sv */
module mips_core_sva #(
        parameter isa_pkg::word_t RESET_PC = '0
) (
        input logic                clk,
        input logic                rst_n,
        input isa_pkg::word_t      ibus_addr_i,
        input pipe_pkg::dbus_req_t dbus_req_i,
        input logic                dbus_stall_i
);

        // A stalled data request must not move until the memory accepts it.
        assert property (@(posedge clk) disable iff (!rst_n)
                dbus_stall_i |=> $stable(dbus_req_i))
        else $error("dbus request changed while dbus_stall_i was high");

        assert property (@(posedge clk) disable iff (!rst_n)
                !(dbus_req_i.read && dbus_req_i.write))
        else $error("dbus read and write strobes high together");

        // On the first edge after reset.
        assert property (@(posedge clk) $rose(rst_n) |->
                (!dbus_req_i.read && !dbus_req_i.write && ibus_addr_i == RESET_PC))
        else $error("dbus strobe active or PC off the reset vector after reset");

endmodule

/* bench/tb_mips_core.sv */
module tb_mips_core;

        import isa_pkg::*;
        import pipe_pkg::*;

        localparam word_t    RESET_PC  = 32'h0000_0040;
        localparam word_t    DATA_BASE = 32'h0000_1000;
        localparam int       PROG_MAX  = 256;
        localparam reg_idx_t BASE_REG  = 5'd28;   // Holds DATA_BASE, never a random target.

        logic      clk;
        logic      rst_n;
        word_t     ibus_addr;
        logic      ibus_read;
        word_t     ibus_rdata;
        logic      ibus_stall;
        dbus_req_t dbus_req;
        word_t     dbus_rdata;
        logic      dbus_stall;
        word_t     prog [PROG_MAX];
        int        prog_len;
        word_t     exp_addr [$];
        word_t     exp_data [$];
        int        got;
        int        value_errors;
        int        other_errors;
        int        cycles;
        int        cycle_limit;
        logic      done;

        mips_core #(.RESET_PC(RESET_PC)) i_mips_core (
                .clk(clk), .rst_n(rst_n),
                .ibus_addr_o(ibus_addr), .ibus_read_o(ibus_read),
                .ibus_rdata_i(ibus_rdata), .ibus_stall_i(ibus_stall),
                .dbus_req_o(dbus_req), .dbus_rdata_i(dbus_rdata), .dbus_stall_i(dbus_stall)
        );

        bus_memory #(.IMEM_BASE(RESET_PC)) i_bus_memory (
                .clk(clk), .rst_n(rst_n),
                .ibus_addr_i(ibus_addr), .ibus_read_i(ibus_read),
                .ibus_rdata_o(ibus_rdata), .ibus_stall_o(ibus_stall),
                .dbus_req_i(dbus_req), .dbus_rdata_o(dbus_rdata), .dbus_stall_o(dbus_stall)
        );

        bind mips_core mips_core_sva #(.RESET_PC(RESET_PC)) i_mips_core_sva (
                .clk(clk), .rst_n(rst_n), .ibus_addr_i(ibus_addr_o),
                .dbus_req_i(dbus_req_o), .dbus_stall_i(dbus_stall_i)
        );

        always #50 clk = ~clk;

        function automatic word_t enc_r(logic [5:0] fn, reg_idx_t rs, reg_idx_t rt,
                                        reg_idx_t rd, logic [4:0] sh);
                return {OP_SPECIAL, rs, rt, rd, sh, fn};
        endfunction

        function automatic word_t enc_i(logic [5:0] op, reg_idx_t rs, reg_idx_t rt,
                                        logic [15:0] imm);
                return {op, rs, rt, imm};
        endfunction

        function automatic reg_idx_t rand_reg();
                return 5'($urandom_range(1, 8));   // Few registers, many dependencies.
        endfunction

        function automatic logic [15:0] rand_offset();
                return 16'(4 * $urandom_range(0, 15));
        endfunction

        function automatic word_t fill_word(word_t addr);
                return (addr * 32'h9e37_79b1) ^ 32'h5bd1_e995;
        endfunction

        task automatic emit(word_t w);
                prog[prog_len] = w;
                prog_len++;
        endtask

        task automatic emit_simple();
                int       sel;
                reg_idx_t a;
                reg_idx_t b;
                reg_idx_t d;
                logic [5:0] fn;
                sel = $urandom_range(0, 99);
                a = rand_reg();
                b = rand_reg();
                d = rand_reg();
                case ($urandom_range(0, 6))
                0: fn = FN_ADDU;
                1: fn = FN_SUBU;
                2: fn = FN_AND;
                3: fn = FN_OR;
                4: fn = FN_XOR;
                5: fn = FN_SLT;
                default: fn = FN_SLL;
                endcase
                if (sel < 45) begin
                        if (fn == FN_SLL) emit(enc_r(fn, 5'd0, a, d, 5'($urandom)));
                        else emit(enc_r(fn, a, b, d, 5'd0));
                end else if (sel < 65) begin
                        emit(enc_i(sel < 55 ? OP_ADDIU : OP_ORI, a, d, 16'($urandom)));
                end else if (sel < 80) begin
                        emit(enc_i(OP_LW, BASE_REG, d, rand_offset()));
                end else begin
                        emit(enc_i(OP_SW, BASE_REG, a, rand_offset()));
                end
        endtask

        task automatic gen_program();
                int       sel;
                int       k;
                reg_idx_t a;
                reg_idx_t b;
                reg_idx_t d;
                prog_len = 0;
                for (int i = 0; i < PROG_MAX; i++) prog[i] = '0;
                emit(enc_i(OP_LUI, 5'd0, BASE_REG, DATA_BASE[31:16]));
                emit(enc_i(OP_ORI, BASE_REG, BASE_REG, DATA_BASE[15:0]));
                while (prog_len < 180) begin
                        sel = $urandom_range(0, 99);
                        a = rand_reg();
                        b = rand_reg();
                        d = rand_reg();
                        if (sel < 12) begin
                                emit(enc_i(OP_LUI, 5'd0, d, 16'($urandom)));
                                emit(enc_i(OP_ORI, d, d, 16'($urandom)));
                        end else if (sel < 66) begin
                                emit_simple();
                        end else if (sel < 76) begin
                                emit(enc_i(OP_LW, BASE_REG, d, rand_offset()));   // Load-use pair.
                                emit(enc_r(FN_ADDU, d, b, a, 5'd0));
                        end else if (sel < 86) begin
                                emit(enc_r(FN_ADDU, a, b, d, 5'd0));
                                emit(enc_r(FN_XOR, d, b, a, 5'd0));
                                emit(enc_i(OP_SW, BASE_REG, a, rand_offset()));
                        end else begin
                                // Forward branch over k instructions after the delay slot.
                                k = $urandom_range(0, 3);
                                emit(enc_i(sel < 93 ? OP_BEQ : OP_BNE, a, b, 16'(k + 1)));
                                emit_simple();
                        end
                end
                for (int r = 1; r <= 8; r++) emit(enc_i(OP_SW, BASE_REG, 5'(r), 16'(4 * (r + 7))));
                emit(enc_i(OP_BEQ, 5'd0, 5'd0, 16'hffff));
                emit('0);
        endtask

        // Sequential model with one delay slot, collects the stores in order.
        function automatic void ref_run();
                word_t       regs [32];
                word_t       mem [16];
                word_t       pc;
                word_t       npc;
                word_t       nxt;
                word_t       ins;
                word_t       a;
                word_t       b;
                word_t       sx;
                word_t       addr;
                int          steps;
                for (int i = 0; i < 32; i++) regs[i] = '0;
                for (int i = 0; i < 16; i++) mem[i] = fill_word(DATA_BASE + 32'(4 * i));
                pc = RESET_PC;
                npc = RESET_PC + 32'd4;
                steps = 0;
                while (int'((pc - RESET_PC) >> 2) != prog_len - 2 && steps < 4 * PROG_MAX) begin
                        ins = prog[int'((pc - RESET_PC) >> 2)];
                        a = regs[ins[25:21]];
                        b = regs[ins[20:16]];
                        sx = {{16{ins[15]}}, ins[15:0]};
                        addr = a + sx;
                        nxt = npc + 32'd4;
                        case (ins[31:26])
                        OP_SPECIAL: begin
                                case (ins[5:0])
                                FN_ADDU: regs[ins[15:11]] = a + b;
                                FN_SUBU: regs[ins[15:11]] = a - b;
                                FN_AND:  regs[ins[15:11]] = a & b;
                                FN_OR:   regs[ins[15:11]] = a | b;
                                FN_XOR:  regs[ins[15:11]] = a ^ b;
                                FN_SLT:  regs[ins[15:11]] = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                                FN_SLL:  regs[ins[15:11]] = b << ins[10:6];
                                default: ;
                                endcase
                        end
                        OP_ADDIU: regs[ins[20:16]] = a + sx;
                        OP_ORI:   regs[ins[20:16]] = a | {16'b0, ins[15:0]};
                        OP_LUI:   regs[ins[20:16]] = {ins[15:0], 16'b0};
                        OP_LW:    regs[ins[20:16]] = mem[addr[5:2]];
                        OP_SW: begin
                                mem[addr[5:2]] = b;
                                exp_addr.push_back(addr);
                                exp_data.push_back(b);
                        end
                        OP_BEQ: if (a == b) nxt = pc + 32'd4 + (sx << 2);
                        OP_BNE: if (a != b) nxt = pc + 32'd4 + (sx << 2);
                        default: ;
                        endcase
                        regs[0] = '0;
                        pc = npc;
                        npc = nxt;
                        steps++;
                end
        endfunction

        task automatic check_value(string name, word_t expected, word_t actual);
                if (expected !== actual) begin
                        value_errors++;
                        $display("FAIL %s: expected %h, actual %h", name, expected, actual);
                end
        endtask

        // Compare every completed store against the reference trace.
        always @(posedge clk) begin
                if (rst_n && dbus_req.write && !dbus_stall) begin
                        if (got < exp_addr.size()) begin
                                check_value($sformatf("store %0d address", got), exp_addr[got],
                                            dbus_req.addr);
                                check_value($sformatf("store %0d data", got), exp_data[got],
                                            dbus_req.wdata);
                        end else begin
                                other_errors++;
                                $display("Unexpected extra store to address %h", dbus_req.addr);
                        end
                        got++;
                end
        end

        always @(posedge clk) begin
                if (rst_n && !done) begin
                        cycles++;
                        if (cycles > cycle_limit) begin
                                other_errors++;
                                $display("Timeout after %0d cycles, only %0d of %0d stores seen",
                                         cycles, got, exp_addr.size());
                                $display("Errors: %0d value mismatches, %0d other",
                                         value_errors, other_errors);
                                $display("Finished with errors");
                                $finish;
                        end
                end
        end

        initial begin
                clk = 1'b0;
                rst_n = 1'b0;
                done = 1'b0;
                got = 0;
                cycles = 0;
                value_errors = 0;
                other_errors = 0;
                void'($urandom(32'h24f8));
                gen_program();
                for (int i = 0; i < PROG_MAX; i++) i_bus_memory.imem[i] = prog[i];
                for (int i = 0; i < 16; i++) i_bus_memory.dmem[i] <= fill_word(DATA_BASE + 32'(4 * i));
                ref_run();
                cycle_limit = prog_len * 4 + 200;
                repeat (3) @(posedge clk);
                @(negedge clk);
                rst_n = 1'b1;
                wait (got >= exp_addr.size());
                repeat (20) @(posedge clk);   // Window for stray stores.
                done = 1'b1;
                $display("Errors: %0d value mismatches, %0d other", value_errors, other_errors);
                if (value_errors + other_errors == 0) begin
                        $display("Finished with no errors");
                end else begin
                        $display("Finished with errors");
                end
                $finish;
        end

endmodule

/* project.f */
rtl/isa_pkg.sv
rtl/pipe_pkg.sv
rtl/stage_reg.sv
rtl/reg_file.sv
rtl/fetch_unit.sv
rtl/decode_unit.sv
rtl/alu_unit.sv
rtl/hazard_ctl.sv
rtl/mips_core.sv
bench/mips_core_sva.sv
bench/bus_memory.sv
bench/tb_mips_core.sv

/* rtl/alu_unit.sv */
module alu_unit (
        input  pipe_pkg::id_ex_t id_ex_i,
        output pipe_pkg::ex_mm_t ex_mm_o
);

        import isa_pkg::*;
        import pipe_pkg::*;

        word_t a;
        word_t b;
        word_t result;

        assign a = id_ex_i.op_a;
        assign b = id_ex_i.use_imm ? id_ex_i.op_b : id_ex_i.store_data;

        always_comb begin
                case (id_ex_i.alu_op)
                ALU_ADD: result = a + b;        // Also the load/store address.
                ALU_SUB: result = a - b;
                ALU_AND: result = a & b;
                ALU_OR:  result = a | b;
                ALU_XOR: result = a ^ b;
                ALU_SLT: result = {31'b0, $signed(a) < $signed(b)};
                ALU_SLL: result = b << id_ex_i.shamt;
                ALU_LUI: result = {b[15:0], 16'b0};
                default: result = '0;
                endcase
        end

        assign ex_mm_o = '{mem_op: id_ex_i.mem_op,
                           rd: id_ex_i.rd,
                           result: result,
                           store_data: id_ex_i.store_data};

endmodule

/* rtl/decode_unit.sv */
module decode_unit (
        input  pipe_pkg::if_id_t  if_id_i,
        input  isa_pkg::word_t    rf_a_i,
        input  isa_pkg::word_t    rf_b_i,
        output isa_pkg::reg_idx_t rs_o,
        output isa_pkg::reg_idx_t rt_o,
        input  pipe_pkg::ex_mm_t  ex_i,
        input  pipe_pkg::mm_wb_t  mm_fwd_i,
        input  pipe_pkg::mm_wb_t  wb_i,
        output pipe_pkg::id_ex_t  id_ex_o,
        output logic              branch_taken_o,
        output isa_pkg::word_t    branch_target_o
);

        import isa_pkg::*;
        import pipe_pkg::*;

        logic [5:0]  opcode;
        logic [5:0]  funct;
        reg_idx_t    rd_field;
        logic [15:0] imm;
        word_t       imm_ext;
        word_t       rs_val;
        word_t       rt_val;
        alu_op_e     alu_op;
        mem_op_e     mem_op;
        reg_idx_t    dest;
        logic        use_imm;
        logic        sign_ext;

        assign opcode   = if_id_i.instr[31:26];
        assign rs_o     = if_id_i.instr[25:21];
        assign rt_o     = if_id_i.instr[20:16];
        assign rd_field = if_id_i.instr[15:11];
        assign funct    = if_id_i.instr[5:0];
        assign imm      = if_id_i.instr[15:0];

        // Newest producer wins. A load in execute has no data yet.
        function automatic word_t fwd(input reg_idx_t idx, input word_t rf_val);
                word_t val;
                if (idx == '0) begin
                        val = '0;
                end else if (ex_i.mem_op != MEM_LOAD && ex_i.rd == idx) begin
                        val = ex_i.result;
                end else if (mm_fwd_i.we && mm_fwd_i.rd == idx) begin
                        val = mm_fwd_i.value;
                end else if (wb_i.we && wb_i.rd == idx) begin
                        val = wb_i.value;
                end else begin
                        val = rf_val;
                end
                return val;
        endfunction

        assign rs_val = fwd(rs_o, rf_a_i);
        assign rt_val = fwd(rt_o, rf_b_i);

        always_comb begin
                alu_op   = ALU_ADD;
                mem_op   = MEM_NONE;
                dest     = '0;          // Unknown encodings write nothing.
                use_imm  = 1'b1;
                sign_ext = 1'b1;
                case (opcode)
                OP_SPECIAL: begin
                        use_imm = 1'b0;
                        dest    = rd_field;
                        case (funct)
                        FN_ADDU: alu_op = ALU_ADD;
                        FN_SUBU: alu_op = ALU_SUB;
                        FN_AND:  alu_op = ALU_AND;
                        FN_OR:   alu_op = ALU_OR;
                        FN_XOR:  alu_op = ALU_XOR;
                        FN_SLT:  alu_op = ALU_SLT;
                        FN_SLL:  alu_op = ALU_SLL;
                        default: dest = '0;
                        endcase
                end
                OP_ADDIU: dest = rt_o;
                OP_ORI: begin
                        alu_op   = ALU_OR;
                        sign_ext = 1'b0;
                        dest     = rt_o;
                end
                OP_LUI: begin
                        alu_op   = ALU_LUI;
                        sign_ext = 1'b0;
                        dest     = rt_o;
                end
                OP_LW: begin
                        mem_op = MEM_LOAD;
                        dest   = rt_o;
                end
                OP_SW: mem_op = MEM_STORE;
                default: ;
                endcase
        end

        assign imm_ext = sign_ext ? {{16{imm[15]}}, imm} : {16'b0, imm};

        assign id_ex_o = '{alu_op: alu_op, mem_op: mem_op, rd: dest,
                           op_a: rs_val, op_b: imm_ext, store_data: rt_val,
                           shamt: if_id_i.instr[10:6], use_imm: use_imm};

        // Branch resolves here. Target is relative to the delay slot.
        assign branch_taken_o = (opcode == OP_BEQ && rs_val == rt_val) ||
                                (opcode == OP_BNE && rs_val != rt_val);
        assign branch_target_o = if_id_i.pc + 32'd4 + {{14{imm[15]}}, imm, 2'b00};

endmodule

/* rtl/fetch_unit.sv */
module fetch_unit #(
        parameter isa_pkg::word_t RESET_PC = '0
) (
        input  logic           clk,
        input  logic           rst_n,
        input  logic           en_i,
        input  logic           branch_taken_i,
        input  isa_pkg::word_t branch_target_i,
        output isa_pkg::word_t pc_o
);

        import isa_pkg::*;

        word_t pc_next;

        // The branch sits in decode while its delay slot is fetched.
        assign pc_next = branch_taken_i ? branch_target_i : pc_o + 32'd4;

        always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                        pc_o <= RESET_PC;
                end else if (en_i) begin
                        pc_o <= pc_next;
                end
        end

endmodule

/* rtl/hazard_ctl.sv */
module hazard_ctl (
        input  logic               ibus_stall_i,
        input  logic               dbus_stall_i,
        input  isa_pkg::mem_op_e   ex_mem_op_i,
        input  isa_pkg::reg_idx_t  ex_rd_i,
        input  isa_pkg::reg_idx_t  id_rs_i,
        input  isa_pkg::reg_idx_t  id_rt_i,
        output logic               en_pc_o,
        output logic               en_if_id_o,
        output logic               en_id_ex_o,
        output logic               en_ex_mm_o,
        output logic               en_mm_wb_o
);

        import isa_pkg::*;

        logic load_use;

        assign load_use = (ex_mem_op_i == MEM_LOAD) && (ex_rd_i != '0) &&
                          (ex_rd_i == id_rs_i || ex_rd_i == id_rt_i);

        always_comb begin
                if (dbus_stall_i) begin
                        {en_pc_o, en_if_id_o, en_id_ex_o, en_ex_mm_o, en_mm_wb_o} = 5'b00000;
                end else if (load_use || ibus_stall_i) begin
                        // Front end holds, a bubble goes into execute.
                        {en_pc_o, en_if_id_o, en_id_ex_o, en_ex_mm_o, en_mm_wb_o} = 5'b00011;
                end else begin
                        {en_pc_o, en_if_id_o, en_id_ex_o, en_ex_mm_o, en_mm_wb_o} = 5'b11111;
                end
        end

endmodule

/* rtl/isa_pkg.sv */
package isa_pkg;

        typedef logic [31:0] word_t;
        typedef logic [4:0]  reg_idx_t;

        // Primary opcodes, instr[31:26].
        localparam logic [5:0] OP_SPECIAL = 6'h00;
        localparam logic [5:0] OP_BEQ     = 6'h04;
        localparam logic [5:0] OP_BNE     = 6'h05;
        localparam logic [5:0] OP_ADDIU   = 6'h09;
        localparam logic [5:0] OP_ORI     = 6'h0d;
        localparam logic [5:0] OP_LUI     = 6'h0f;
        localparam logic [5:0] OP_LW      = 6'h23;
        localparam logic [5:0] OP_SW      = 6'h2b;

        // SPECIAL function codes, instr[5:0].
        localparam logic [5:0] FN_SLL  = 6'h00;
        localparam logic [5:0] FN_ADDU = 6'h21;
        localparam logic [5:0] FN_SUBU = 6'h23;
        localparam logic [5:0] FN_AND  = 6'h24;
        localparam logic [5:0] FN_OR   = 6'h25;
        localparam logic [5:0] FN_XOR  = 6'h26;
        localparam logic [5:0] FN_SLT  = 6'h2a;

        typedef enum logic [3:0] {
                ALU_ADD = 4'd0,
                ALU_SUB = 4'd1,
                ALU_AND = 4'd2,
                ALU_OR  = 4'd3,
                ALU_XOR = 4'd4,
                ALU_SLT = 4'd5,
                ALU_SLL = 4'd6,
                ALU_LUI = 4'd7
        } alu_op_e;

        typedef enum logic [1:0] {
                MEM_NONE  = 2'd0,
                MEM_LOAD  = 2'd1,
                MEM_STORE = 2'd2
        } mem_op_e;

endpackage

/* rtl/mips_core.sv */
module mips_core #(
        parameter isa_pkg::word_t RESET_PC = '0
) (
        input  logic                clk,
        input  logic                rst_n,
        output isa_pkg::word_t      ibus_addr_o,
        output logic                ibus_read_o,
        input  isa_pkg::word_t      ibus_rdata_i,
        input  logic                ibus_stall_i,
        output pipe_pkg::dbus_req_t dbus_req_o,
        input  isa_pkg::word_t      dbus_rdata_i,
        input  logic                dbus_stall_i
);

        import isa_pkg::*;
        import pipe_pkg::*;

        logic     en_pc;
        logic     en_if_id;
        logic     en_id_ex;
        logic     en_ex_mm;
        logic     en_mm_wb;
        word_t    pc;
        logic     branch_taken;
        word_t    branch_target;
        reg_idx_t rs;
        reg_idx_t rt;
        word_t    rf_a;
        word_t    rf_b;
        if_id_t   if_id_d;
        if_id_t   if_id_q;
        id_ex_t   id_ex_d;
        id_ex_t   id_ex_q;
        ex_mm_t   ex_mm_d;
        ex_mm_t   ex_mm_q;
        mm_wb_t   mm_wb_d;
        mm_wb_t   mm_wb_q;

        fetch_unit #(.RESET_PC(RESET_PC)) i_fetch (
                .clk(clk), .rst_n(rst_n), .en_i(en_pc),
                .branch_taken_i(branch_taken), .branch_target_i(branch_target),
                .pc_o(pc)
        );

        assign ibus_addr_o = pc;
        assign ibus_read_o = rst_n;     // Fetch runs whenever out of reset.
        assign if_id_d     = '{instr: ibus_rdata_i, pc: pc};

        stage_reg #(.payload_t(if_id_t), .BUBBLE(IF_ID_BUBBLE)) i_if_id (
                .clk(clk), .rst_n(rst_n), .en_i(en_if_id), .next_en_i(en_id_ex),
                .d_i(if_id_d), .q_o(if_id_q)
        );

        reg_file i_reg_file (
                .clk(clk), .rst_n(rst_n),
                .raddr_a_i(rs), .raddr_b_i(rt),
                .rdata_a_o(rf_a), .rdata_b_o(rf_b),
                .wb_i(mm_wb_q)
        );

        decode_unit i_decode (
                .if_id_i(if_id_q), .rf_a_i(rf_a), .rf_b_i(rf_b),
                .rs_o(rs), .rt_o(rt),
                .ex_i(ex_mm_d), .mm_fwd_i(mm_wb_d), .wb_i(mm_wb_q),
                .id_ex_o(id_ex_d),
                .branch_taken_o(branch_taken), .branch_target_o(branch_target)
        );

        stage_reg #(.payload_t(id_ex_t), .BUBBLE(ID_EX_BUBBLE)) i_id_ex (
                .clk(clk), .rst_n(rst_n), .en_i(en_id_ex), .next_en_i(en_ex_mm),
                .d_i(id_ex_d), .q_o(id_ex_q)
        );

        alu_unit i_alu (.id_ex_i(id_ex_q), .ex_mm_o(ex_mm_d));

        stage_reg #(.payload_t(ex_mm_t), .BUBBLE(EX_MM_BUBBLE)) i_ex_mm (
                .clk(clk), .rst_n(rst_n), .en_i(en_ex_mm), .next_en_i(en_mm_wb),
                .d_i(ex_mm_d), .q_o(ex_mm_q)
        );

        // Memory stage.
        assign dbus_req_o = '{addr: ex_mm_q.result, wdata: ex_mm_q.store_data,
                              read: ex_mm_q.mem_op == MEM_LOAD,
                              write: ex_mm_q.mem_op == MEM_STORE};

        assign mm_wb_d = '{we: ex_mm_q.rd != '0, rd: ex_mm_q.rd,
                           value: (ex_mm_q.mem_op == MEM_LOAD) ? dbus_rdata_i
                                                               : ex_mm_q.result};

        // Writeback has no register of its own, so the last stage always drains.
        stage_reg #(.payload_t(mm_wb_t), .BUBBLE(MM_WB_BUBBLE)) i_mm_wb (
                .clk(clk), .rst_n(rst_n), .en_i(en_mm_wb), .next_en_i(1'b1),
                .d_i(mm_wb_d), .q_o(mm_wb_q)
        );

        hazard_ctl i_hazard (
                .ibus_stall_i(ibus_stall_i), .dbus_stall_i(dbus_stall_i),
                .ex_mem_op_i(id_ex_q.mem_op), .ex_rd_i(id_ex_q.rd),
                .id_rs_i(rs), .id_rt_i(rt),
                .en_pc_o(en_pc), .en_if_id_o(en_if_id), .en_id_ex_o(en_id_ex),
                .en_ex_mm_o(en_ex_mm), .en_mm_wb_o(en_mm_wb)
        );

endmodule

/* rtl/pipe_pkg.sv */
package pipe_pkg;

        import isa_pkg::*;

        typedef struct packed {
                word_t instr;
                word_t pc;
        } if_id_t;

        // Operand B carries the extended immediate, store_data the rt value.
        typedef struct packed {
                alu_op_e    alu_op;
                mem_op_e    mem_op;
                reg_idx_t   rd;
                word_t      op_a;
                word_t      op_b;
                word_t      store_data;
                logic [4:0] shamt;
                logic       use_imm;
        } id_ex_t;

        typedef struct packed {
                mem_op_e  mem_op;
                reg_idx_t rd;
                word_t    result;        // ALU result or effective address.
                word_t    store_data;
        } ex_mm_t;

        typedef struct packed {
                logic     we;
                reg_idx_t rd;
                word_t    value;
        } mm_wb_t;

        typedef struct packed {
                word_t addr;
                word_t wdata;
                logic  read;
                logic  write;
        } dbus_req_t;

        // All zeros is a no-op that writes nothing.
        localparam if_id_t IF_ID_BUBBLE = '0;
        localparam id_ex_t ID_EX_BUBBLE = '0;
        localparam ex_mm_t EX_MM_BUBBLE = '0;
        localparam mm_wb_t MM_WB_BUBBLE = '0;

endpackage

/* rtl/reg_file.sv */
module reg_file (
        input  logic              clk,
        input  logic              rst_n,
        input  isa_pkg::reg_idx_t raddr_a_i,
        input  isa_pkg::reg_idx_t raddr_b_i,
        output isa_pkg::word_t    rdata_a_o,
        output isa_pkg::word_t    rdata_b_o,
        input  pipe_pkg::mm_wb_t  wb_i
);

        import isa_pkg::*;

        word_t regs [32];
        logic  wr_en;

        assign wr_en = wb_i.we && (wb_i.rd != '0);

        always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                        for (int i = 0; i < 32; i++) begin
                                regs[i] <= '0;
                        end
                end else if (wr_en) begin
                        regs[wb_i.rd] <= wb_i.value;
                end
        end

        // Write data shows up on the read ports in the same cycle.
        assign rdata_a_o = (wr_en && wb_i.rd == raddr_a_i) ? wb_i.value : regs[raddr_a_i];
        assign rdata_b_o = (wr_en && wb_i.rd == raddr_b_i) ? wb_i.value : regs[raddr_b_i];

endmodule

/* rtl/stage_reg.sv */
module stage_reg #(
        parameter type payload_t = logic [31:0],
        parameter payload_t BUBBLE = '0
) (
        input  logic     clk,
        input  logic     rst_n,
        input  logic     en_i,
        input  logic     next_en_i,
        input  payload_t d_i,
        output payload_t q_o
);

        always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                        q_o <= BUBBLE;
                end else if (en_i) begin
                        q_o <= d_i;
                end else if (next_en_i) begin
                        q_o <= BUBBLE;   // Stalled here while the next stage moves on.
                end
        end

endmodule

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -j 0 --top-module tb_mips_core -f project.f -o sim_tb
./obj_dir/sim_tb > sim.log 2>&1 || true
cat sim.log
if grep -q "Finished with errors" sim.log || ! grep -q "Finished with no errors" sim.log; then
        exit 1
fi
exit 0
